//--- design/sparse_conv_macros.svh
`ifndef SPARSE_CONV_MACROS_SVH
`define SPARSE_CONV_MACROS_SVH

////////////////////
// Chunk geometry
////////////////////

// Elements per IFM chunk
`define MEM_SIZE 32

// Elements moved per bus beat
`define BUS_SIZE 8

// Chunks held in the IFM memory
`define IFM_CHUNK_NUM 4

// Beats needed to fill one chunk
`define DAT_CYC_NUM (`MEM_SIZE / `BUS_SIZE)

`endif

//--- design/sparse_conv_pkg.sv
`default_nettype none

`include "sparse_conv_macros.svh"

package sparse_conv_pkg;

	// One signed feature or weight byte
	typedef logic signed [7:0] elem_t;

	// One beat of payload, lane 0 in the low byte
	typedef elem_t [`BUS_SIZE-1:0] beat_data_t;

	// Sparsemap bits for one beat
	typedef logic [`BUS_SIZE-1:0] beat_map_t;

	typedef logic signed [31:0] acc_t;

	// APB register offsets
	typedef enum logic [7:0] {
		REG_CTRL        = 8'h00,
		REG_STATUS      = 8'h04,
		REG_RESULT      = 8'h08,
		REG_IFM_PTR     = 8'h0C,
		REG_IFM_MAP     = 8'h10,
		REG_IFM_DATA_LO = 8'h14,
		REG_IFM_DATA_HI = 8'h18,
		REG_FILTER_BASE = 8'h20
	} reg_addr_e;

	// Dot engine FSM
	typedef enum logic [1:0] {
		ENG_IDLE,
		ENG_RUN,
		ENG_DONE
	} eng_state_e;

endpackage

`default_nettype wire

//--- design/ifm_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "sparse_conv_macros.svh"

module ifm_mem #(
	localparam int CHUNK_W = $clog2(`IFM_CHUNK_NUM),
	localparam int DAT_W   = $clog2(`DAT_CYC_NUM)
) (
	input  wire logic                        clk_i,
	input  wire logic                        rst_i,

	// Write port, one beat per valid
	input  wire logic                        wr_valid_i,
	input  wire logic [CHUNK_W-1:0]          wr_chunk_i,
	input  wire logic [DAT_W-1:0]            wr_dat_i,
	input  wire sparse_conv_pkg::beat_map_t  wr_sparsemap_i,
	input  wire sparse_conv_pkg::beat_data_t wr_nonzero_data_i,

	// Read port
	input  wire logic [CHUNK_W-1:0]          rd_chunk_i,
	input  wire logic [DAT_W-1:0]            rd_dat_i,
	output sparse_conv_pkg::beat_map_t       rd_sparsemap_o,
	output sparse_conv_pkg::beat_data_t      rd_nonzero_data_o
);

	////////////////////
	// Storage
	////////////////////

	// Each chunk is kept as DAT_CYC_NUM beat slots
	sparse_conv_pkg::beat_map_t  [`IFM_CHUNK_NUM-1:0][`DAT_CYC_NUM-1:0] mem_map_r;
	sparse_conv_pkg::beat_data_t [`IFM_CHUNK_NUM-1:0][`DAT_CYC_NUM-1:0] mem_data_r;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			mem_map_r  <= '0;
			mem_data_r <= '0;
		end else if (wr_valid_i) begin
			mem_map_r[wr_chunk_i][wr_dat_i]  <= wr_sparsemap_i;
			mem_data_r[wr_chunk_i][wr_dat_i] <= wr_nonzero_data_i;
		end
	end

	////////////////////
	// Read
	////////////////////

	// Addressed beat comes straight out, no read latency
	assign rd_sparsemap_o    = mem_map_r[rd_chunk_i][rd_dat_i];
	assign rd_nonzero_data_o = mem_data_r[rd_chunk_i][rd_dat_i];

endmodule

`default_nettype wire

//--- design/ifm_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "sparse_conv_macros.svh"

module ifm_apb_regs #(
	localparam int CHUNK_W   = $clog2(`IFM_CHUNK_NUM),
	localparam int DAT_W     = $clog2(`DAT_CYC_NUM),
	localparam int FLT_WORDS = `MEM_SIZE / 4,
	localparam int FLT_IDX_W = $clog2(FLT_WORDS)
) (
	input  wire logic                   clk_i,
	input  wire logic                   rst_i,

	// APB slave, zero wait
	input  wire logic                   psel_i,
	input  wire logic                   penable_i,
	input  wire logic                   pwrite_i,
	input  wire logic [7:0]             paddr_i,
	input  wire logic [31:0]            pwdata_i,
	output logic [31:0]                 prdata_o,
	output logic                        pslverr_o,

	// Engine status
	input  wire logic                   busy_i,
	input  wire logic                   done_i,
	input  wire sparse_conv_pkg::acc_t  result_i,

	// IFM memory write port
	output logic                        ifm_wr_valid_o,
	output logic [CHUNK_W-1:0]          ifm_wr_chunk_o,
	output logic [DAT_W-1:0]            ifm_wr_dat_o,
	output sparse_conv_pkg::beat_map_t  ifm_wr_sparsemap_o,
	output sparse_conv_pkg::beat_data_t ifm_wr_nonzero_data_o,

	// Engine control and filter load
	output logic                        start_o,
	output logic [CHUNK_W-1:0]          start_chunk_o,
	output logic                        flt_wr_o,
	output logic [FLT_IDX_W-1:0]        flt_word_idx_o,
	output logic [31:0]                 flt_word_o
);

	logic                       wr_acc;
	logic                       rd_acc;
	logic                       addr_ok;
	logic                       flt_hit;
	logic                       reject;
	logic [7:0]                 flt_off;
	logic [31:0]                rd_data;
	logic                       ctrl_wr;
	logic                       ptr_wr;
	logic                       map_wr;
	logic                       lo_wr;
	logic                       hi_wr;
	logic                       flt_wr;

	sparse_conv_pkg::beat_map_t map_stage_r;
	logic [31:0]                lo_stage_r;
	logic [CHUNK_W-1:0]         ctrl_chunk_r;
	logic [CHUNK_W-1:0]         ptr_chunk_r;
	logic [DAT_W-1:0]           ptr_dat_r;

	////////////////////
	// Decode
	////////////////////

	assign wr_acc = psel_i & penable_i & pwrite_i;
	assign rd_acc = psel_i & penable_i & ~pwrite_i;

	// Filter window, word aligned
	assign flt_off = paddr_i - 8'(sparse_conv_pkg::REG_FILTER_BASE);
	assign flt_hit = (flt_off < 8'(FLT_WORDS * 4)) && (paddr_i[1:0] == 2'b00);

	assign ctrl_wr = wr_acc && (paddr_i == sparse_conv_pkg::REG_CTRL);
	assign ptr_wr  = wr_acc && (paddr_i == sparse_conv_pkg::REG_IFM_PTR);
	assign map_wr  = wr_acc && (paddr_i == sparse_conv_pkg::REG_IFM_MAP);
	assign lo_wr   = wr_acc && (paddr_i == sparse_conv_pkg::REG_IFM_DATA_LO);
	assign hi_wr   = wr_acc && (paddr_i == sparse_conv_pkg::REG_IFM_DATA_HI);
	assign flt_wr  = wr_acc && flt_hit;

	// Dropped while the engine runs
	assign reject = busy_i && ((ctrl_wr && pwdata_i[0]) || lo_wr || hi_wr || flt_wr);

	always_comb begin
		addr_ok = 1'b1;
		rd_data = '0;
		case (paddr_i)
			sparse_conv_pkg::REG_CTRL:        rd_data = 32'(ctrl_chunk_r) << 2;
			sparse_conv_pkg::REG_STATUS:      rd_data = {30'd0, done_i, busy_i};
			sparse_conv_pkg::REG_RESULT:      rd_data = result_i;
			sparse_conv_pkg::REG_IFM_PTR:     rd_data = (32'(ptr_chunk_r) << 4) | 32'(ptr_dat_r);
			sparse_conv_pkg::REG_IFM_MAP:     rd_data = 32'(map_stage_r);
			sparse_conv_pkg::REG_IFM_DATA_LO: rd_data = lo_stage_r;
			// Write only, the HI lanes go straight to memory
			sparse_conv_pkg::REG_IFM_DATA_HI: rd_data = '0;
			default:                          addr_ok = flt_hit;
		endcase
	end

	assign prdata_o  = rd_acc ? rd_data : '0;
	assign pslverr_o = psel_i && penable_i && (!addr_ok || reject);

	// Start and filter writes act in the access cycle itself
	assign start_o        = ctrl_wr && pwdata_i[0] && !busy_i;
	assign start_chunk_o  = pwdata_i[2 +: CHUNK_W];
	assign flt_wr_o       = flt_wr && !busy_i;
	assign flt_word_idx_o = flt_off[2 +: FLT_IDX_W];
	assign flt_word_o     = pwdata_i;

	////////////////////
	// Pointer, control
	////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ctrl_chunk_r   <= '0;
			ptr_chunk_r    <= '0;
			ptr_dat_r      <= '0;
			ifm_wr_valid_o <= 1'b0;
		end else begin
			ifm_wr_valid_o <= 1'b0;
			if (ctrl_wr && !reject) begin
				ctrl_chunk_r <= pwdata_i[2 +: CHUNK_W];
			end
			if (ptr_wr) begin
				ptr_dat_r   <= pwdata_i[0 +: DAT_W];
				ptr_chunk_r <= pwdata_i[4 +: CHUNK_W];
			end else if (hi_wr && !reject) begin
				ifm_wr_valid_o <= 1'b1;
				// Auto increment, chunk advances on beat wrap
				if (ptr_dat_r == DAT_W'(`DAT_CYC_NUM - 1)) begin
					ptr_dat_r <= '0;
					if (ptr_chunk_r == CHUNK_W'(`IFM_CHUNK_NUM - 1)) begin
						ptr_chunk_r <= '0;
					end else begin
						ptr_chunk_r <= ptr_chunk_r + 1'b1;
					end
				end else begin
					ptr_dat_r <= ptr_dat_r + 1'b1;
				end
			end
		end
	end

	// Beat staging
	always_ff @(posedge clk_i) begin
		if (map_wr) begin
			map_stage_r <= pwdata_i[`BUS_SIZE-1:0];
		end
		if (lo_wr && !reject) begin
			lo_stage_r <= pwdata_i;
		end
		if (hi_wr) begin
			ifm_wr_chunk_o        <= ptr_chunk_r;
			ifm_wr_dat_o          <= ptr_dat_r;
			ifm_wr_sparsemap_o    <= map_stage_r;
			ifm_wr_nonzero_data_o <= {pwdata_i, lo_stage_r};
		end
	end

endmodule

`default_nettype wire

//--- design/sparse_dot_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "sparse_conv_macros.svh"

module sparse_dot_engine #(
	localparam int CHUNK_W   = $clog2(`IFM_CHUNK_NUM),
	localparam int DAT_W     = $clog2(`DAT_CYC_NUM),
	localparam int STEP_W    = $clog2(`DAT_CYC_NUM + 1),
	localparam int FLT_WORDS = `MEM_SIZE / 4,
	localparam int FLT_IDX_W = $clog2(FLT_WORDS)
) (
	input  wire logic                        clk_i,
	input  wire logic                        rst_i,

	input  wire logic                        start_i,
	input  wire logic [CHUNK_W-1:0]          start_chunk_i,

	// Filter load, four weights per word
	input  wire logic                        flt_wr_i,
	input  wire logic [FLT_IDX_W-1:0]        flt_word_idx_i,
	input  wire logic [31:0]                 flt_word_i,

	// IFM read port
	output logic [CHUNK_W-1:0]               rd_chunk_o,
	output logic [DAT_W-1:0]                 rd_dat_o,
	input  wire sparse_conv_pkg::beat_map_t  rd_sparsemap_i,
	input  wire sparse_conv_pkg::beat_data_t rd_nonzero_data_i,

	output logic                             busy_o,
	output logic                             done_o,
	output sparse_conv_pkg::acc_t            result_o
);

	sparse_conv_pkg::elem_t [`MEM_SIZE-1:0] weight_r;
	sparse_conv_pkg::beat_data_t            wt_beat;
	sparse_conv_pkg::eng_state_e            state_r;
	logic [STEP_W-1:0]                      step_r;
	logic [CHUNK_W-1:0]                     chunk_r;
	sparse_conv_pkg::acc_t                  beat_sum;
	sparse_conv_pkg::acc_t                  psum_r;
	sparse_conv_pkg::acc_t                  acc_r;

	////////////////////
	// Filter weights
	////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			weight_r <= '0;
		end else if (flt_wr_i) begin
			weight_r[flt_word_idx_i * 4 +: 4] <= flt_word_i;
		end
	end

	// Weights lined up with the beat being read
	assign wt_beat = weight_r[rd_dat_o * `BUS_SIZE +: `BUS_SIZE];

	////////////////////
	// Masked MAC
	////////////////////

	always_comb begin
		logic signed [15:0] prod;
		beat_sum = '0;
		for (int i = 0; i < `BUS_SIZE; i++) begin
			prod = rd_nonzero_data_i[i] * wt_beat[i];
			// Lanes with a clear map bit are skipped
			if (rd_sparsemap_i[i]) begin
				beat_sum = beat_sum + sparse_conv_pkg::acc_t'(prod);
			end
		end
	end

	// Beat sum is registered once before it enters the accumulator
	always_ff @(posedge clk_i) begin
		if (start_i && (state_r != sparse_conv_pkg::ENG_RUN)) begin
			psum_r <= '0;
			acc_r  <= '0;
		end else if (state_r == sparse_conv_pkg::ENG_RUN) begin
			psum_r <= beat_sum;
			acc_r  <= acc_r + psum_r;
		end
	end

	////////////////////
	// Control FSM
	////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_r  <= sparse_conv_pkg::ENG_IDLE;
			step_r   <= '0;
			chunk_r  <= '0;
			result_o <= '0;
		end else begin
			case (state_r)
				sparse_conv_pkg::ENG_IDLE, sparse_conv_pkg::ENG_DONE: begin
					if (start_i) begin
						state_r <= sparse_conv_pkg::ENG_RUN;
						step_r  <= '0;
						chunk_r <= start_chunk_i;
					end
				end
				sparse_conv_pkg::ENG_RUN: begin
					step_r <= step_r + 1'b1;
					// Extra step drains the last beat sum
					if (step_r == STEP_W'(`DAT_CYC_NUM)) begin
						result_o <= acc_r + psum_r;
						state_r  <= sparse_conv_pkg::ENG_DONE;
					end
				end
				default: state_r <= sparse_conv_pkg::ENG_IDLE;
			endcase
		end
	end

	assign rd_chunk_o = chunk_r;
	assign rd_dat_o   = step_r[DAT_W-1:0];
	assign busy_o     = (state_r == sparse_conv_pkg::ENG_RUN);
	assign done_o     = (state_r == sparse_conv_pkg::ENG_DONE);

endmodule

`default_nettype wire

//--- design/sparse_conv_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "sparse_conv_macros.svh"

module sparse_conv_top #(
	localparam int CHUNK_W   = $clog2(`IFM_CHUNK_NUM),
	localparam int DAT_W     = $clog2(`DAT_CYC_NUM),
	localparam int FLT_IDX_W = $clog2(`MEM_SIZE / 4)
) (
	input  wire logic        clk_i,
	input  wire logic        rst_i,

	input  wire logic        psel_i,
	input  wire logic        penable_i,
	input  wire logic        pwrite_i,
	input  wire logic [7:0]  paddr_i,
	input  wire logic [31:0] pwdata_i,
	output logic [31:0]      prdata_o,
	output logic             pslverr_o
);

	// Register block to memory
	logic                        ifm_wr_valid;
	logic [CHUNK_W-1:0]          ifm_wr_chunk;
	logic [DAT_W-1:0]            ifm_wr_dat;
	sparse_conv_pkg::beat_map_t  ifm_wr_sparsemap;
	sparse_conv_pkg::beat_data_t ifm_wr_nonzero_data;

	// Register block to engine
	logic                        start;
	logic [CHUNK_W-1:0]          start_chunk;
	logic                        flt_wr;
	logic [FLT_IDX_W-1:0]        flt_word_idx;
	logic [31:0]                 flt_word;

	// Engine side
	logic [CHUNK_W-1:0]          rd_chunk;
	logic [DAT_W-1:0]            rd_dat;
	sparse_conv_pkg::beat_map_t  rd_sparsemap;
	sparse_conv_pkg::beat_data_t rd_nonzero_data;
	logic                        busy;
	logic                        done;
	sparse_conv_pkg::acc_t       result;

	ifm_apb_regs i_regs (
		.clk_i                 (clk_i),
		.rst_i                 (rst_i),
		.psel_i                (psel_i),
		.penable_i             (penable_i),
		.pwrite_i              (pwrite_i),
		.paddr_i               (paddr_i),
		.pwdata_i              (pwdata_i),
		.prdata_o              (prdata_o),
		.pslverr_o             (pslverr_o),
		.busy_i                (busy),
		.done_i                (done),
		.result_i              (result),
		.ifm_wr_valid_o        (ifm_wr_valid),
		.ifm_wr_chunk_o        (ifm_wr_chunk),
		.ifm_wr_dat_o          (ifm_wr_dat),
		.ifm_wr_sparsemap_o    (ifm_wr_sparsemap),
		.ifm_wr_nonzero_data_o (ifm_wr_nonzero_data),
		.start_o               (start),
		.start_chunk_o         (start_chunk),
		.flt_wr_o              (flt_wr),
		.flt_word_idx_o        (flt_word_idx),
		.flt_word_o            (flt_word)
	);

	ifm_mem i_ifm_mem (
		.clk_i             (clk_i),
		.rst_i             (rst_i),
		.wr_valid_i        (ifm_wr_valid),
		.wr_chunk_i        (ifm_wr_chunk),
		.wr_dat_i          (ifm_wr_dat),
		.wr_sparsemap_i    (ifm_wr_sparsemap),
		.wr_nonzero_data_i (ifm_wr_nonzero_data),
		.rd_chunk_i        (rd_chunk),
		.rd_dat_i          (rd_dat),
		.rd_sparsemap_o    (rd_sparsemap),
		.rd_nonzero_data_o (rd_nonzero_data)
	);

	sparse_dot_engine i_engine (
		.clk_i             (clk_i),
		.rst_i             (rst_i),
		.start_i           (start),
		.start_chunk_i     (start_chunk),
		.flt_wr_i          (flt_wr),
		.flt_word_idx_i    (flt_word_idx),
		.flt_word_i        (flt_word),
		.rd_chunk_o        (rd_chunk),
		.rd_dat_o          (rd_dat),
		.rd_sparsemap_i    (rd_sparsemap),
		.rd_nonzero_data_i (rd_nonzero_data),
		.busy_o            (busy),
		.done_o            (done),
		.result_o          (result)
	);

endmodule

`default_nettype wire

//--- tb/tb_sparse_conv.sv
`timescale 1ns/1ps
`default_nettype none

`include "sparse_conv_macros.svh"

module tb_sparse_conv;

	localparam int CLK_PERIOD  = 20;
	// Whole sequence is well under 700 cycles
	localparam int CYCLE_LIMIT = 4000;
	localparam int RUN_CYCLES  = `DAT_CYC_NUM + 1;

	logic        clk_i;
	logic        rst_i;
	logic        psel_i;
	logic        penable_i;
	logic        pwrite_i;
	logic [7:0]  paddr_i;
	logic [31:0] pwdata_i;
	logic [31:0] prdata_o;
	logic        pslverr_o;

	int          cyc_cnt = 0;
	int          access_cyc;
	logic [31:0] lfsr_r = 32'h97b3_9279;

	// Shadow of IFM contents, weights and write pointer
	logic                   map_sh  [`IFM_CHUNK_NUM][`MEM_SIZE];
	sparse_conv_pkg::elem_t data_sh [`IFM_CHUNK_NUM][`MEM_SIZE];
	sparse_conv_pkg::elem_t wt_sh   [`MEM_SIZE];
	sparse_conv_pkg::acc_t  prev_res[`IFM_CHUNK_NUM];
	int                     ptr_chunk_m;
	int                     ptr_dat_m;

	sparse_conv_top i_dut (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.psel_i    (psel_i),
		.penable_i (penable_i),
		.pwrite_i  (pwrite_i),
		.paddr_i   (paddr_i),
		.pwdata_i  (pwdata_i),
		.prdata_o  (prdata_o),
		.pslverr_o (pslverr_o)
	);

	initial begin
		clk_i = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk_i = ~clk_i;
		end
	end

	always @(posedge clk_i) begin
		cyc_cnt <= cyc_cnt + 1;
		if (cyc_cnt >= CYCLE_LIMIT) begin
			abort_run($sformatf("Timeout: run did not end within %0d cycles", CYCLE_LIMIT));
		end
	end

	////////////////////
	// Helpers
	////////////////////

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "Simulation stopped on error");
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_r = lfsr_step(lfsr_r);
			v = {v[30:0], lfsr_r[0]};
		end
		return v;
	endfunction

	// Masked dot product of one chunk against the filter
	function automatic sparse_conv_pkg::acc_t ref_dot(input int chunk);
		sparse_conv_pkg::acc_t sum;
		sum = '0;
		for (int e = 0; e < `MEM_SIZE; e++) begin
			if (map_sh[chunk][e]) begin
				sum = sum + sparse_conv_pkg::acc_t'(data_sh[chunk][e]) *
					sparse_conv_pkg::acc_t'(wt_sh[e]);
			end
		end
		return sum;
	endfunction

	task automatic check_acc(input string name, input sparse_conv_pkg::acc_t got,
		input sparse_conv_pkg::acc_t exp);
		if (got !== exp) begin
			abort_run($sformatf("MISMATCH time %0t: %s got %0d, expected %0d",
				$time, name, got, exp));
		end
	endtask

	task automatic check_status(input logic [31:0] status, input logic busy_exp,
		input logic done_exp);
		if (status[1:0] !== {done_exp, busy_exp}) begin
			abort_run($sformatf("MISMATCH time %0t: STATUS done,busy got %b%b, expected %b%b",
				$time, status[1], status[0], done_exp, busy_exp));
		end
	endtask

	task automatic check_err(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("MISMATCH time %0t: pslverr on %s got %b, expected %b",
				$time, name, got, exp));
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("MISMATCH time %0t: %s got 0x%08h, expected 0x%08h",
				$time, name, got, exp));
		end
	endtask

	////////////////////
	// APB driver
	////////////////////

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
		@(negedge clk_i);
		psel_i    = 1'b1;
		penable_i = 1'b0;
		pwrite_i  = 1'b1;
		paddr_i   = addr;
		pwdata_i  = data;
		@(negedge clk_i);
		penable_i = 1'b1;
		// Mid access cycle, response is settled
		#(CLK_PERIOD / 4);
		err        = pslverr_o;
		access_cyc = cyc_cnt;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
		@(negedge clk_i);
		psel_i    = 1'b1;
		penable_i = 1'b0;
		pwrite_i  = 1'b0;
		paddr_i   = addr;
		@(negedge clk_i);
		penable_i = 1'b1;
		#(CLK_PERIOD / 4);
		data       = prdata_o;
		err        = pslverr_o;
		access_cyc = cyc_cnt;
	endtask

	task automatic apb_idle();
		@(negedge clk_i);
		psel_i    = 1'b0;
		penable_i = 1'b0;
		pwrite_i  = 1'b0;
	endtask

	////////////////////
	// Sequences
	////////////////////

	task automatic write_beat(input logic [7:0] map, input sparse_conv_pkg::beat_data_t d);
		logic err;
		int   base;
		apb_write(sparse_conv_pkg::REG_IFM_MAP, 32'(map), err);
		check_err("IFM_MAP", err, 1'b0);
		apb_write(sparse_conv_pkg::REG_IFM_DATA_LO, {d[3], d[2], d[1], d[0]}, err);
		check_err("IFM_DATA_LO", err, 1'b0);
		apb_write(sparse_conv_pkg::REG_IFM_DATA_HI, {d[7], d[6], d[5], d[4]}, err);
		check_err("IFM_DATA_HI", err, 1'b0);
		base = ptr_dat_m * `BUS_SIZE;
		for (int lane = 0; lane < `BUS_SIZE; lane++) begin
			map_sh[ptr_chunk_m][base + lane]  = map[lane];
			data_sh[ptr_chunk_m][base + lane] = d[lane];
		end
		// Beat index wraps into the next chunk
		if (ptr_dat_m == `DAT_CYC_NUM - 1) begin
			ptr_dat_m   = 0;
			ptr_chunk_m = (ptr_chunk_m + 1) % `IFM_CHUNK_NUM;
		end else begin
			ptr_dat_m = ptr_dat_m + 1;
		end
	endtask

	task automatic check_ptr();
		logic [31:0] rd;
		logic        err;
		apb_read(sparse_conv_pkg::REG_IFM_PTR, rd, err);
		check_err("IFM_PTR read", err, 1'b0);
		check_word("IFM_PTR", rd, 32'((ptr_chunk_m << 4) | ptr_dat_m));
	endtask

	task automatic start_run(input int chunk, output int start_cyc);
		logic err;
		apb_write(sparse_conv_pkg::REG_CTRL, 32'((chunk << 2) | 1), err);
		check_err("CTRL start", err, 1'b0);
		start_cyc = access_cyc;
	endtask

	// Polls STATUS and checks each sample against the cycle count since start
	task automatic finish_run(input int chunk, input int start_cyc,
		output sparse_conv_pkg::acc_t res);
		logic [31:0] rd;
		logic        err;
		logic        exp_done;
		do begin
			apb_read(sparse_conv_pkg::REG_STATUS, rd, err);
			exp_done = (access_cyc - start_cyc - 1) >= RUN_CYCLES;
			check_status(rd, !exp_done, exp_done);
		end while (!rd[1]);
		apb_read(sparse_conv_pkg::REG_RESULT, rd, err);
		res = rd;
		check_acc("RESULT", res, ref_dot(chunk));
		// Done holds until the next start
		apb_read(sparse_conv_pkg::REG_STATUS, rd, err);
		check_status(rd, 1'b0, 1'b1);
	endtask

	task automatic check_run(input int chunk, input logic gap, output sparse_conv_pkg::acc_t res);
		int start_cyc;
		start_run(chunk, start_cyc);
		// One idle cycle shifts the poll phase by a cycle
		if (gap) begin
			apb_idle();
		end
		finish_run(chunk, start_cyc, res);
	endtask

	////////////////////
	// Main test
	////////////////////

	initial begin
		logic [31:0]                 rd;
		logic [31:0]                 r;
		logic                        err;
		logic [7:0]                  map;
		int                          start_cyc;
		sparse_conv_pkg::acc_t       res;
		sparse_conv_pkg::beat_data_t d;

		rst_i       = 1'b1;
		psel_i      = 1'b0;
		penable_i   = 1'b0;
		pwrite_i    = 1'b0;
		paddr_i     = '0;
		pwdata_i    = '0;
		ptr_chunk_m = 0;
		ptr_dat_m   = 0;
		for (int c = 0; c < `IFM_CHUNK_NUM; c++) begin
			for (int e = 0; e < `MEM_SIZE; e++) begin
				map_sh[c][e]  = 1'b0;
				data_sh[c][e] = '0;
			end
		end
		for (int e = 0; e < `MEM_SIZE; e++) begin
			wt_sh[e] = '0;
		end
		repeat (5) @(negedge clk_i);
		rst_i = 1'b0;

		// Reset state
		apb_read(sparse_conv_pkg::REG_STATUS, rd, err);
		check_status(rd, 1'b0, 1'b0);
		apb_read(sparse_conv_pkg::REG_RESULT, rd, err);
		check_acc("RESULT", rd, '0);
		check_ptr();

		// Filter words, lowest element in the low byte
		for (int w = 0; w < `MEM_SIZE / 4; w++) begin
			r = rand_bits(32);
			apb_write(8'(sparse_conv_pkg::REG_FILTER_BASE + 4 * w), r, err);
			check_err("FILTER", err, 1'b0);
			for (int k = 0; k < 4; k++) begin
				wt_sh[4 * w + k] = r[8 * k +: 8];
			end
		end

		// Fill all chunks through pointer auto increment
		for (int c = 0; c < `IFM_CHUNK_NUM; c++) begin
			for (int b = 0; b < `DAT_CYC_NUM; b++) begin
				r   = rand_bits(8);
				map = r[7:0];
				for (int lane = 0; lane < `BUS_SIZE; lane++) begin
					r       = rand_bits(8);
					d[lane] = r[7:0];
				end
				write_beat(map, d);
			end
			check_ptr();
		end

		for (int c = 0; c < `IFM_CHUNK_NUM; c++) begin
			check_run(c, (c % 2) == 1, res);
			prev_res[c] = ref_dot(c);
		end

		// Chunk 2 gets an empty map over nonzero data
		apb_write(sparse_conv_pkg::REG_IFM_PTR, 32'h20, err);
		check_err("IFM_PTR write", err, 1'b0);
		ptr_chunk_m = 2;
		ptr_dat_m   = 0;
		for (int b = 0; b < `DAT_CYC_NUM; b++) begin
			for (int lane = 0; lane < `BUS_SIZE; lane++) begin
				r       = rand_bits(8);
				d[lane] = (r[7:0] == 8'h00) ? 8'h01 : r[7:0];
			end
			write_beat(8'h00, d);
		end
		check_ptr();
		for (int c = 0; c < `IFM_CHUNK_NUM; c++) begin
			check_run(c, (c % 2) == 0, res);
			check_acc("RESULT after rewrite", res, (c == 2) ? '0 : prev_res[c]);
		end

		// Full staged beat, visible in chunk 3 if a busy HI write got through
		apb_write(sparse_conv_pkg::REG_IFM_MAP, 32'h0000_00ff, err);
		check_err("IFM_MAP", err, 1'b0);
		apb_write(sparse_conv_pkg::REG_IFM_DATA_LO, rand_bits(32), err);
		check_err("IFM_DATA_LO", err, 1'b0);

		start_run(1, start_cyc);
		apb_write(sparse_conv_pkg::REG_IFM_DATA_HI, rand_bits(32), err);
		check_err("IFM_DATA_HI while busy", err, 1'b1);
		finish_run(1, start_cyc, res);

		start_run(0, start_cyc);
		apb_write(sparse_conv_pkg::REG_FILTER_BASE, ~{wt_sh[3], wt_sh[2], wt_sh[1], wt_sh[0]}, err);
		check_err("FILTER while busy", err, 1'b1);
		finish_run(0, start_cyc, res);

		start_run(3, start_cyc);
		apb_write(sparse_conv_pkg::REG_CTRL, 32'h0000_0005, err);
		check_err("CTRL start while busy", err, 1'b1);
		finish_run(3, start_cyc, res);

		// Chunk select still holds the last accepted start
		apb_read(sparse_conv_pkg::REG_CTRL, rd, err);
		check_err("CTRL read", err, 1'b0);
		check_word("CTRL", rd, 32'(3 << 2));

		check_ptr();
		for (int c = 0; c < `IFM_CHUNK_NUM; c++) begin
			check_run(c, 1'b0, res);
		end

		// Unmapped offsets below and above the filter window
		apb_read(8'h1C, rd, err);
		check_err("unmapped read", err, 1'b1);
		check_word("PRDATA unmapped", rd, 32'h0);
		apb_write(8'h40, 32'hdead_beef, err);
		check_err("unmapped write", err, 1'b1);
		apb_idle();

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+design
design/sparse_conv_pkg.sv
design/ifm_mem.sv
design/ifm_apb_regs.sv
design/sparse_dot_engine.sv
design/sparse_conv_top.sv
tb/tb_sparse_conv.sv
